// ==== list.f ====
+incdir+include
hw/bsg_link_pkg.sv
hw/bsg_tag_pkg.sv
hw/bsg_tag_client.sv
hw/bsg_link_fifo.sv
hw/bsg_link_downstream.sv
hw/bsg_wh_loopback.sv
hw/bsg_link_upstream.sv
hw/bsg_chip_block.sv
sim/bsg_chip_block_assert.sv
sim/tb_bsg_chip_block.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build the loopback testbench with verilator and run it

cd "$(dirname "$0")" || exit 1

top=tb_bsg_chip_block

verilator --binary --timing --assert -Wno-fatal \
  --top-module "$top" -f list.f -o "V$top"
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

out=$("./obj_dir/V$top" 2>&1)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -qx "Finished with no errors"; then
  exit 0
fi

echo "simulation did not report a pass"
exit 1

// ==== sim/tb_bsg_chip_block.sv ====
`timescale 1ns/1ns
`include "bsg_link_consts.svh"

module tb_bsg_chip_block
  import bsg_link_pkg::*;
  import bsg_tag_pkg::*;
();

  localparam int clk_period_lp = 20;
  // packets per test phase
  localparam int n_boot_lp  = 3;
  localparam int n_mix_lp   = 20;
  localparam int n_stall_lp = 6;
  localparam int n_recfg_lp = 7;
  localparam int n_pkts_lp  = n_boot_lp + n_mix_lp + n_stall_lp + n_recfg_lp;
  localparam int wd_cycles_lp = n_pkts_lp * 40 + 2000;

  logic         core_clk;
  logic         rst_n;
  logic         tag_en;
  logic         tag_data;
  logic         link_v_in;
  bsg_wh_flit_t link_data_in;
  logic         link_token_out;
  logic         link_v_out;
  bsg_wh_flit_t link_data_out;
  logic         link_token_in;

  integer       seed;
  int           data_errs;
  int           flow_errs;
  // flits waiting to go in, flits expected out
  bsg_wh_flit_t tx_q[$];
  bsg_wh_flit_t exp_q[$];
  bsg_wh_flit_t exp_flit;
  // free slots in the dut receive fifo
  int           credits;
  int           rx_cnt;
  int           tok_sent;
  int           tok_owed;
  int           base;
  logic         quiet;
  logic         withhold;
  logic [`BSG_WH_CORD_WIDTH-1:0] cur_cord;
  logic [`BSG_WH_CORD_WIDTH-1:0] old_cord;

  bsg_chip_block bsg_chip_block_i
  (
    .core_clk_i   (core_clk),
    .rst_n_i      (rst_n),
    .tag_en_i     (tag_en),
    .tag_data_i   (tag_data),
    .link_v_i     (link_v_in),
    .link_data_i  (link_data_in),
    .link_token_o (link_token_out),
    .link_v_o     (link_v_out),
    .link_data_o  (link_data_out),
    .link_token_i (link_token_in)
  );

  initial
  begin
    core_clk = 1'b0;
    forever #(clk_period_lp / 2) core_clk = ~core_clk;
  end

  initial
  begin
    repeat (wd_cycles_lp) @(posedge core_clk);
    $display("watchdog expired before the test sequence completed");
    $display("errors: data %0d, flow %0d", data_errs, flow_errs);
    $display("Finished with errors");
    $finish;
  end

  ////////////////////////////////////////////////////////////
  // packet source and model
  ////////////////////////////////////////////////////////////

  // queue one packet, expected echo follows the current cord
  task automatic push_packet(input logic [`BSG_WH_CORD_WIDTH-1:0] dest,
                             input logic [`BSG_WH_LEN_WIDTH-1:0] len);
    bsg_wh_header_s hdr;
    bsg_wh_header_s echo;
    bsg_wh_flit_t   body;
    logic           keep;
    begin
      hdr = bsg_wh_header_s'(bsg_wh_flit_t'($random(seed)));
      hdr.dest_cord = dest;
      hdr.len = len;
      echo = hdr;
      echo.src_cord = hdr.dest_cord;
      echo.dest_cord = hdr.src_cord;
      keep = (dest == cur_cord);
      tx_q.push_back(bsg_wh_flit_t'(hdr));
      if (keep)
        exp_q.push_back(bsg_wh_flit_t'(echo));
      for (int i = 0; i < len; i++)
      begin
        body = bsg_wh_flit_t'($random(seed));
        tx_q.push_back(body);
        if (keep)
          exp_q.push_back(body);
      end
    end
  endtask

  // sender, one flit per cycle while credits last
  always @(posedge core_clk)
  begin
    #2;
    if (rst_n && link_token_out)
      credits = credits + `BSG_LINK_TOKEN_DECIMATION;
    assert (credits <= `BSG_LINK_FIFO_DEPTH)
    else
    begin
      $display("dut returned more tokens than flits it received");
      flow_errs++;
    end
    if (rst_n && (tx_q.size() != 0) && (credits > 0))
    begin
      link_v_in = 1'b1;
      link_data_in = tx_q.pop_front();
      credits = credits - 1;
    end
    else
    begin
      link_v_in = 1'b0;
      link_data_in = bsg_wh_flit_t'($random(seed));
    end
  end

  ////////////////////////////////////////////////////////////
  // receiver, checker and token return
  ////////////////////////////////////////////////////////////

  always @(posedge core_clk)
  begin
    #2;
    if (rst_n)
    begin
      // disabled chip stays silent on both links
      assert (!(quiet && (link_v_out || link_token_out)))
      else
      begin
        $display("link activity while the chip is not enabled");
        flow_errs++;
      end
      if (link_v_out)
      begin
        rx_cnt++;
        assert (rx_cnt <= `BSG_LINK_FIFO_DEPTH + tok_sent * `BSG_LINK_TOKEN_DECIMATION)
        else
        begin
          $display("more flits sent than the returned tokens allow");
          flow_errs++;
        end
        assert (exp_q.size() != 0)
        else
        begin
          $display("flit %h came out with none expected", link_data_out);
          data_errs++;
        end
        if (exp_q.size() != 0)
        begin
          exp_flit = exp_q.pop_front();
          assert (link_data_out == exp_flit)
          else
          begin
            $display("error: link_data_o is %h, expected %h", link_data_out, exp_flit);
            data_errs++;
          end
        end
        if (rx_cnt % `BSG_LINK_TOKEN_DECIMATION == 0)
          tok_owed++;
      end
      // random delay before each token goes back
      if ((tok_owed > 0) && !withhold && (($random(seed) & 3) == 0))
      begin
        link_token_in = 1'b1;
        tok_owed--;
        tok_sent++;
      end
      else
        link_token_in = 1'b0;
    end
  end

  ////////////////////////////////////////////////////////////
  // tag frames and waits
  ////////////////////////////////////////////////////////////

  // msb first, config lands a cycle after the last bit
  task automatic send_tag(input logic [`BSG_TAG_ID_WIDTH-1:0] id, input logic en,
                          input logic [`BSG_WH_CORD_WIDTH-1:0] cord);
    bsg_tag_packet_s pkt;
    begin
      pkt.start = 1'b1;
      pkt.node_id = id;
      pkt.payload.enable = en;
      pkt.payload.cord = cord;
      for (int i = $bits(pkt) - 1; i >= 0; i--)
      begin
        @(posedge core_clk);
        #2;
        tag_en = 1'b1;
        tag_data = pkt[i];
      end
      @(posedge core_clk);
      #2;
      tag_en = 1'b0;
      tag_data = 1'b0;
      repeat (2) @(posedge core_clk);
      #2;
    end
  endtask

  task automatic wait_output_idle(input int cycles);
    int idle;
    begin
      idle = 0;
      while (idle < cycles)
      begin
        @(posedge core_clk);
        #2;
        if (link_v_out)
          idle = 0;
        else
          idle++;
      end
    end
  endtask

  // everything sent and every expected flit seen
  task automatic wait_drain();
    begin
      while ((tx_q.size() != 0) || (exp_q.size() != 0))
      begin
        @(posedge core_clk);
        #2;
      end
      wait_output_idle(30);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // test sequence
  ////////////////////////////////////////////////////////////

  initial
  begin
    seed = 32'hb2eb_9d05;
    rst_n = 1'b0;
    tag_en = 1'b0;
    tag_data = 1'b0;
    link_v_in = 1'b0;
    link_data_in = '0;
    link_token_in = 1'b0;
    data_errs = 0;
    flow_errs = 0;
    credits = `BSG_LINK_FIFO_DEPTH;
    rx_cnt = 0;
    tok_sent = 0;
    tok_owed = 0;
    quiet = 1'b1;
    withhold = 1'b0;
    cur_cord = '0;
    repeat (5) @(posedge core_clk);
    #2;
    rst_n = 1'b1;

    // packets for cord 0 pile up while disabled
    repeat (n_boot_lp) push_packet('0, 4'($random(seed)));
    repeat (40) @(posedge core_clk);
    #2;
    // foreign node id, must change nothing
    send_tag(4'd5, 1'b1, 4'd5);
    repeat (20) @(posedge core_clk);
    #2;
    quiet = 1'b0;
    send_tag(`BSG_TAG_NODE_ID, 1'b1, cur_cord);
    wait_drain();

    // half the packets match, the rest are dropped whole
    for (int i = 0; i < n_mix_lp; i++)
    begin
      if ($random(seed) & 1)
        push_packet(cur_cord, 4'($random(seed)));
      else
        push_packet(4'($random(seed)), 4'($random(seed)));
    end
    wait_drain();

    // no tokens back, output stops on an exhausted credit count
    withhold = 1'b1;
    repeat (n_stall_lp) push_packet(cur_cord, 4'(4 + ($random(seed) & 7)));
    wait_output_idle(30);
    assert (rx_cnt == `BSG_LINK_FIFO_DEPTH + tok_sent * `BSG_LINK_TOKEN_DECIMATION)
    else
    begin
      $display("output stalled before the credits were used up");
      flow_errs++;
    end
    withhold = 1'b0;
    wait_drain();

    // cord change while a long packet is still streaming
    old_cord = cur_cord;
    push_packet(cur_cord, 4'd15);
    base = rx_cnt;
    while (rx_cnt == base)
    begin
      @(posedge core_clk);
      #2;
    end
    send_tag(`BSG_TAG_NODE_ID, 1'b1, old_cord ^ 4'h9);
    cur_cord = old_cord ^ 4'h9;
    for (int i = 0; i < n_recfg_lp - 1; i++)
      push_packet((i % 2) ? cur_cord : old_cord, 4'($random(seed)));
    wait_drain();

    $display("errors: data %0d, flow %0d", data_errs, flow_errs);
    if ((data_errs == 0) && (flow_errs == 0))
      $display("Finished with no errors");
    else
      $display("Finished with errors");
    $finish;
  end

endmodule

// ==== sim/bsg_chip_block_assert.sv ====
`timescale 1ns/1ns
`include "bsg_link_consts.svh"

module bsg_chip_block_assert
  import bsg_link_pkg::*;
(
  input logic             core_clk_i,
  input logic             rst_n_i,
  input bsg_link_credit_t credit_i,
  input logic             link_v_i,
  input logic             token_i,
  input logic             wr_i,
  input logic             full_i
);

  localparam bsg_link_credit_t credit_max_lp = `BSG_LINK_FIFO_DEPTH;

  // credits as the link partner sees them, from the pins alone
  int pin_credit_r;

  always_ff @(posedge core_clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
      pin_credit_r <= `BSG_LINK_FIFO_DEPTH;
    else
      pin_credit_r <= pin_credit_r - int'(link_v_i)
                      + (token_i ? `BSG_LINK_TOKEN_DECIMATION : 0);
  end

  ////////////////////////////////////////////////////////////
  // link credits
  ////////////////////////////////////////////////////////////

  // tokens only return slots that were used
  credit_bound: assert property (@(posedge core_clk_i) disable iff (!rst_n_i)
    credit_i <= credit_max_lp)
    else $error("credit count above the receive fifo depth");

  // every flit on the pins spends a credit still held
  send_with_credit: assert property (@(posedge core_clk_i) disable iff (!rst_n_i)
    link_v_i |-> (pin_credit_r > 0))
    else $error("flit sent on the link with no credit left");

  ////////////////////////////////////////////////////////////
  // receive buffer
  ////////////////////////////////////////////////////////////

  no_overflow: assert property (@(posedge core_clk_i) disable iff (!rst_n_i)
    !(wr_i && full_i))
    else $error("receive fifo written while full");

endmodule

// credit side checks on the transmit link
bind bsg_link_upstream bsg_chip_block_assert upstream_assert_i
(
  .core_clk_i (core_clk_i),
  .rst_n_i    (rst_n_i),
  .credit_i   (credit_r),
  .link_v_i   (link_v_o),
  .token_i    (link_token_i),
  .wr_i       (1'b0),
  .full_i     (1'b0)
);

// overflow check on the downstream buffer
bind bsg_link_fifo bsg_chip_block_assert fifo_assert_i
(
  .core_clk_i (core_clk_i),
  .rst_n_i    (rst_n_i),
  .credit_i   ('0),
  .link_v_i   (1'b0),
  .token_i    (1'b0),
  .wr_i       (v_i),
  .full_i     (!ready_o)
);

// ==== hw/bsg_chip_block.sv ====
`timescale 1ns/1ns

module bsg_chip_block
  import bsg_link_pkg::*;
  import bsg_tag_pkg::*;
(
  input  logic         core_clk_i,
  input  logic         rst_n_i,
  // serial configuration
  input  logic         tag_en_i,
  input  logic         tag_data_i,
  // receive link
  input  logic         link_v_i,
  input  bsg_wh_flit_t link_data_i,
  output logic         link_token_o,
  // transmit link
  output logic         link_v_o,
  output bsg_wh_flit_t link_data_o,
  input  logic         link_token_i
);

  bsg_chip_cfg_s cfg_lo;

  // downstream to loopback
  logic          ds_v_lo;
  bsg_wh_flit_t  ds_data_lo;
  logic          ds_ready_li;

  // loopback to upstream
  logic          lb_v_lo;
  bsg_wh_flit_t  lb_data_lo;
  logic          lb_ready_li;

  ////////////////////////////////////////////////////////////
  // tag client
  ////////////////////////////////////////////////////////////

  bsg_tag_client tag_client_i
  (
    .core_clk_i (core_clk_i),
    .rst_n_i    (rst_n_i),
    .tag_en_i   (tag_en_i),
    .tag_data_i (tag_data_i),
    .cfg_o      (cfg_lo)
  );

  ////////////////////////////////////////////////////////////
  // link in, loopback, link out
  ////////////////////////////////////////////////////////////

  bsg_link_downstream downstream_i
  (
    .core_clk_i   (core_clk_i),
    .rst_n_i      (rst_n_i),
    .link_v_i     (link_v_i),
    .link_data_i  (link_data_i),
    .link_token_o (link_token_o),
    .v_o          (ds_v_lo),
    .data_o       (ds_data_lo),
    .ready_i      (ds_ready_li)
  );

  bsg_wh_loopback loopback_i
  (
    .core_clk_i (core_clk_i),
    .rst_n_i    (rst_n_i),
    .cfg_i      (cfg_lo),
    .v_i        (ds_v_lo),
    .data_i     (ds_data_lo),
    .ready_o    (ds_ready_li),
    .v_o        (lb_v_lo),
    .data_o     (lb_data_lo),
    .ready_i    (lb_ready_li)
  );

  bsg_link_upstream upstream_i
  (
    .core_clk_i   (core_clk_i),
    .rst_n_i      (rst_n_i),
    .cfg_i        (cfg_lo),
    .v_i          (lb_v_lo),
    .data_i       (lb_data_lo),
    .ready_o      (lb_ready_li),
    .link_v_o     (link_v_o),
    .link_data_o  (link_data_o),
    .link_token_i (link_token_i)
  );

endmodule

// ==== hw/bsg_link_upstream.sv ====
`timescale 1ns/1ns
`include "bsg_link_consts.svh"

module bsg_link_upstream
  import bsg_link_pkg::*;
  import bsg_tag_pkg::*;
(
  input  logic          core_clk_i,
  input  logic          rst_n_i,
  input  bsg_chip_cfg_s cfg_i,
  // from the loopback
  input  logic          v_i,
  input  bsg_wh_flit_t  data_i,
  output logic          ready_o,
  // link pins
  output logic          link_v_o,
  output bsg_wh_flit_t  link_data_o,
  input  logic          link_token_i
);

  localparam bsg_link_credit_t credit_init_lp = `BSG_LINK_FIFO_DEPTH;
  localparam bsg_link_credit_t token_inc_lp   = `BSG_LINK_TOKEN_DECIMATION;

  bsg_link_credit_t credit_r;
  logic             send;
  logic             link_v_r;
  bsg_wh_flit_t     link_data_r;

  ////////////////////////////////////////////////////////////
  // credit flow control
  ////////////////////////////////////////////////////////////

  // stall when disabled or out of credits
  assign ready_o = cfg_i.enable & (credit_r != '0);
  assign send    = v_i & ready_o;

  always_ff @(posedge core_clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      credit_r <= credit_init_lp;
      link_v_r <= 1'b0;
    end
    else
    begin
      link_v_r <= send;
      // one credit per flit out, a token brings back a batch
      case ({send, link_token_i})
        2'b10:   credit_r <= credit_r - 1'b1;
        2'b01:   credit_r <= credit_r + token_inc_lp;
        2'b11:   credit_r <= credit_r + token_inc_lp - 1'b1;
        default: credit_r <= credit_r;
      endcase
    end
  end

  // flit goes out on the pins the cycle after acceptance
  always_ff @(posedge core_clk_i)
  begin
    if (send)
      link_data_r <= data_i;
  end

  assign link_v_o    = link_v_r;
  assign link_data_o = link_data_r;

endmodule

// ==== hw/bsg_wh_loopback.sv ====
`timescale 1ns/1ns
`include "bsg_link_consts.svh"

module bsg_wh_loopback
  import bsg_link_pkg::*;
  import bsg_tag_pkg::*;
(
  input  logic          core_clk_i,
  input  logic          rst_n_i,
  input  bsg_chip_cfg_s cfg_i,
  // from downstream
  input  logic          v_i,
  input  bsg_wh_flit_t  data_i,
  output logic          ready_o,
  // to upstream
  output logic          v_o,
  output bsg_wh_flit_t  data_o,
  input  logic          ready_i
);

  // body flits still to come in the current packet
  logic [`BSG_WH_LEN_WIDTH-1:0] remain_r;
  // forward or drop, latched at the header
  logic                         keep_r;
  logic                         out_v_r;
  bsg_wh_flit_t                 out_data_r;
  bsg_wh_header_s               hdr_in;
  bsg_wh_header_s               hdr_swap;
  logic                         is_header;
  logic                         hdr_match;
  logic                         keep_now;
  logic                         accept;

  ////////////////////////////////////////////////////////////
  // framing and filter
  ////////////////////////////////////////////////////////////

  assign hdr_in    = bsg_wh_header_s'(data_i);
  // nothing left of the previous packet means a header
  assign is_header = (remain_r == '0);
  assign hdr_match = (hdr_in.dest_cord == cfg_i.cord);
  assign keep_now  = is_header ? hdr_match : keep_r;

  // take a flit whenever the output register frees up
  assign ready_o = ~out_v_r | ready_i;
  assign accept  = v_i & ready_o;

  // echo back, src and dest trade places
  always_comb
  begin
    hdr_swap           = hdr_in;
    hdr_swap.src_cord  = hdr_in.dest_cord;
    hdr_swap.dest_cord = hdr_in.src_cord;
  end

  always_ff @(posedge core_clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      remain_r <= '0;
      keep_r   <= 1'b0;
      out_v_r  <= 1'b0;
    end
    else
    begin
      if (accept)
      begin
        if (is_header)
        begin
          remain_r <= hdr_in.len;
          keep_r   <= hdr_match;
        end
        else
          remain_r <= remain_r - 1'b1;
      end
      // dropped flits are swallowed without output
      if (accept && keep_now)
        out_v_r <= 1'b1;
      else if (ready_i)
        out_v_r <= 1'b0;
    end
  end

  // single output stage
  always_ff @(posedge core_clk_i)
  begin
    if (accept && keep_now)
      out_data_r <= is_header ? bsg_wh_flit_t'(hdr_swap) : data_i;
  end

  assign v_o    = out_v_r;
  assign data_o = out_data_r;

endmodule

// ==== hw/bsg_link_downstream.sv ====
`timescale 1ns/1ns
`include "bsg_link_consts.svh"

module bsg_link_downstream
  import bsg_link_pkg::*;
(
  input  logic         core_clk_i,
  input  logic         rst_n_i,
  // link pins
  input  logic         link_v_i,
  input  bsg_wh_flit_t link_data_i,
  output logic         link_token_o,
  // stream toward the loopback
  output logic         v_o,
  output bsg_wh_flit_t data_o,
  input  logic         ready_i
);

  localparam int dec_width_lp = $clog2(`BSG_LINK_TOKEN_DECIMATION + 1);

  logic                    deq;
  logic [dec_width_lp-1:0] deq_cnt_r;
  logic                    token_r;

  ////////////////////////////////////////////////////////////
  // receive buffer
  ////////////////////////////////////////////////////////////

  // sender holds a credit per flit, so there is always room
  // ready of the fifo is left open
  bsg_link_fifo
  #(
    .payload_t (bsg_wh_flit_t),
    .depth_p   (`BSG_LINK_FIFO_DEPTH)
  )
  fifo_i
  (
    .core_clk_i (core_clk_i),
    .rst_n_i    (rst_n_i),
    .v_i        (link_v_i),
    .data_i     (link_data_i),
    .ready_o    (),
    .v_o        (v_o),
    .data_o     (data_o),
    .yumi_i     (deq)
  );

  assign deq = v_o & ready_i;

  ////////////////////////////////////////////////////////////
  // token return
  ////////////////////////////////////////////////////////////

  // one token per decimation count of dequeues
  always_ff @(posedge core_clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      deq_cnt_r <= '0;
      token_r   <= 1'b0;
    end
    else
    begin
      token_r <= 1'b0;
      if (deq)
      begin
        if (deq_cnt_r == dec_width_lp'(`BSG_LINK_TOKEN_DECIMATION - 1))
        begin
          deq_cnt_r <= '0;
          token_r   <= 1'b1;
        end
        else
          deq_cnt_r <= deq_cnt_r + 1'b1;
      end
    end
  end

  // registered, a single cycle pulse
  assign link_token_o = token_r;

endmodule

// ==== hw/bsg_link_fifo.sv ====
`timescale 1ns/1ns

module bsg_link_fifo
#(
  parameter type payload_t = logic,
  parameter int  depth_p   = 8
)
(
  input  logic     core_clk_i,
  input  logic     rst_n_i,
  input  logic     v_i,
  input  payload_t data_i,
  output logic     ready_o,
  output logic     v_o,
  output payload_t data_o,
  input  logic     yumi_i
);

  localparam int ptr_width_lp = (depth_p > 1) ? $clog2(depth_p) : 1;
  localparam int cnt_width_lp = $clog2(depth_p + 1);

  payload_t                mem_r [depth_p];
  logic [ptr_width_lp-1:0] wr_ptr_r;
  logic [ptr_width_lp-1:0] rd_ptr_r;
  logic [cnt_width_lp-1:0] count_r;
  logic                    enq;
  logic                    deq;

  // full blocks the write side
  assign ready_o = (count_r != cnt_width_lp'(depth_p));
  assign v_o     = (count_r != '0);
  assign data_o  = mem_r[rd_ptr_r];
  assign enq     = v_i & ready_o;
  assign deq     = yumi_i & v_o;

  always_ff @(posedge core_clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      wr_ptr_r <= '0;
      rd_ptr_r <= '0;
      count_r  <= '0;
    end
    else
    begin
      // pointers wrap at depth, not only at powers of two
      if (enq)
        wr_ptr_r <= (wr_ptr_r == ptr_width_lp'(depth_p - 1)) ? '0 : wr_ptr_r + 1'b1;
      if (deq)
        rd_ptr_r <= (rd_ptr_r == ptr_width_lp'(depth_p - 1)) ? '0 : rd_ptr_r + 1'b1;
      case ({enq, deq})
        2'b10:   count_r <= count_r + 1'b1;
        2'b01:   count_r <= count_r - 1'b1;
        default: count_r <= count_r;
      endcase
    end
  end

  // storage, visible at data_o the cycle after the write
  always_ff @(posedge core_clk_i)
  begin
    if (enq)
      mem_r[wr_ptr_r] <= data_i;
  end

endmodule

// ==== hw/bsg_tag_client.sv ====
`timescale 1ns/1ns
`include "bsg_link_consts.svh"

module bsg_tag_client
  import bsg_tag_pkg::*;
(
  input  logic          core_clk_i,
  input  logic          rst_n_i,
  input  logic          tag_en_i,
  input  logic          tag_data_i,
  output bsg_chip_cfg_s cfg_o
);

  // bits behind the start bit
  localparam int frame_bits_lp = $bits(bsg_tag_packet_s) - 1;
  localparam int cnt_width_lp = $clog2(frame_bits_lp + 1);
  localparam logic [`BSG_TAG_ID_WIDTH-1:0] node_id_lp = `BSG_TAG_NODE_ID;

  logic                     busy_r;
  logic [cnt_width_lp-1:0]  cnt_r;
  logic [frame_bits_lp-1:0] shift_r;
  logic                     done_r;
  bsg_tag_packet_s          frame;
  bsg_chip_cfg_s            cfg_r;

  // start bit is implied once a frame is captured
  assign frame = bsg_tag_packet_s'({1'b1, shift_r});

  ////////////////////////////////////////////////////////////
  // frame search and bit counter
  ////////////////////////////////////////////////////////////

  always_ff @(posedge core_clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      busy_r <= 1'b0;
      cnt_r  <= '0;
      done_r <= 1'b0;
    end
    else
    begin
      // done only pulses for one cycle
      done_r <= 1'b0;
      if (tag_en_i)
      begin
        if (!busy_r)
        begin
          // idle line is low, a one opens a frame
          busy_r <= tag_data_i;
          cnt_r  <= '0;
        end
        else
        begin
          cnt_r <= cnt_r + 1'b1;
          // last payload bit
          if (cnt_r == cnt_width_lp'(frame_bits_lp - 1))
          begin
            busy_r <= 1'b0;
            done_r <= 1'b1;
          end
        end
      end
    end
  end

  // id and payload shift in msb first
  always_ff @(posedge core_clk_i)
  begin
    if (tag_en_i && busy_r)
      shift_r <= {shift_r[frame_bits_lp-2:0], tag_data_i};
  end

  // load one cycle after the last bit, foreign ids ignored
  always_ff @(posedge core_clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
      cfg_r <= '0;
    else if (done_r && (frame.node_id == node_id_lp))
      cfg_r <= frame.payload;
  end

  assign cfg_o = cfg_r;

endmodule

// ==== hw/bsg_tag_pkg.sv ====
`include "bsg_link_consts.svh"

package bsg_tag_pkg;

  // node configuration written over tag
  typedef struct packed {
    logic                          enable;
    logic [`BSG_WH_CORD_WIDTH-1:0] cord;
  } bsg_chip_cfg_s;

  // one tag frame, msb goes on the wire first
  // payload carries enable then cord
  typedef struct packed {
    logic                         start;
    logic [`BSG_TAG_ID_WIDTH-1:0] node_id;
    bsg_chip_cfg_s                payload;
  } bsg_tag_packet_s;

endpackage

// ==== hw/bsg_link_pkg.sv ====
`include "bsg_link_consts.svh"

package bsg_link_pkg;

  // raw flit as seen on the link pins
  typedef logic [`BSG_WH_FLIT_WIDTH-1:0] bsg_wh_flit_t;

  ////////////////////////////////////////////////////////////
  // header view of a flit
  ////////////////////////////////////////////////////////////

  // dest sits in the low bits, reserved bits ride along untouched
  typedef struct packed {
    logic [`BSG_WH_FLIT_WIDTH-`BSG_WH_LEN_WIDTH-2*`BSG_WH_CORD_WIDTH-1:0] reserved;
    // body flits that follow
    logic [`BSG_WH_LEN_WIDTH-1:0]  len;
    logic [`BSG_WH_CORD_WIDTH-1:0] src_cord;
    logic [`BSG_WH_CORD_WIDTH-1:0] dest_cord;
  } bsg_wh_header_s;

  // credit counter, holds 0 up to the full fifo depth
  typedef logic [$clog2(`BSG_LINK_FIFO_DEPTH+1)-1:0] bsg_link_credit_t;

endpackage

// ==== include/bsg_link_consts.svh ====
`ifndef BSG_LINK_CONSTS_SVH
`define BSG_LINK_CONSTS_SVH

// wormhole flit format
`define BSG_WH_FLIT_WIDTH 16
`define BSG_WH_CORD_WIDTH 4
// number of body flits behind a header
`define BSG_WH_LEN_WIDTH 4

// receive buffer depth
// sender starts with this many credits
`define BSG_LINK_FIFO_DEPTH 8
// flits covered by one token
`define BSG_LINK_TOKEN_DECIMATION 2

// tag frame is start bit, node id, payload
`define BSG_TAG_ID_WIDTH 4
// id this chip answers to
`define BSG_TAG_NODE_ID 3

`endif
